/* dv/golden_vectors.txt */
// Columns: op addr wdata strb exp_rdata exp_irq, all hex
// op 0 is a read, 1 a write, ff ends the list
0 2000 00000000 0 00000000 0
0 3000 00000000 0 00000000 0
0 4000 00000000 0 00000000 0
0 5000 00000000 0 00000000 0
0 0000 00000000 0 00000007 0
0 0004 00000000 0 00000003 0
0 0008 00000000 0 80000005 0
0 000c 00000000 0 80000005 0
0 0010 00000000 0 80000005 0
0 0014 00000000 0 80000005 0
0 0018 00000000 0 00000000 0
0 001c 00000000 0 00000000 0
1 2000 11223344 f 00000000 0
1 3000 aabbccdd f 00000000 0
1 2000 ffeeddcc 5 00000000 0
0 2000 00000000 0 11ee33cc 0
0 3000 00000000 0 aabbccdd 0
1 4000 55667788 a 00000000 0
0 4000 00000000 0 55007700 0
1 6000 deadbeef f 00000000 0
0 6000 00000000 0 00000000 0
1 7000 01020304 f 00000000 0
0 7004 00000000 0 00000000 0
0 2000 00000000 0 11ee33cc 0
1 5004 00000001 f 00000000 1
1 3004 00000001 f 00000000 1
0 1000 00000000 0 80000001 1
1 1004 00000001 f 00000000 1
0 1000 00000000 0 80000003 1
// irq is still high two cycles after the last ack
1 1004 00000003 f 00000000 1
0 5004 00000000 0 00000000 0
1 1004 00000002 f 00000000 0
0 1000 00000000 0 00000000 0
ff 0 0 0 0 0

/* build.f */
logic/periph_pkg.sv
logic/apb_slot_decoder.sv
logic/mailbox_slot.sv
logic/device_table.sv
logic/intr_ctrl.sv
logic/periph_top.sv
dv/tb_checker.sv
dv/tb_top.sv

/* run_sim.sh */
#!/bin/sh
# Build the peripheral subsystem testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f build.f --top-module tb_top -o tb_top_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_top_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "Test completed successfully" "$LOG"; then
	exit 0
fi
exit 1

/* dv/tb_top.sv */
//###########################################################################
// Peripheral subsystem testbench
// Drives APB accesses from the golden vectors into the DUT, with random
// idle gaps, and reports the outcome
//###########################################################################
`timescale 1ns/100ps
`default_nettype none

module tb_top;

	localparam int          FIELDS        = 6;
	localparam int          MAX_TESTS     = 64;
	localparam int          READY_TIMEOUT = 16;
	localparam int          DRAIN_TIMEOUT = 16;
	localparam logic [31:0] SEED          = 32'h14e2_5127;

	logic                            clk24mhz;
	logic                            rst_p;
	logic                            psel;
	logic                            penable;
	logic                            pwrite;
	logic [periph_pkg::ADDR_W-1:0]   paddr;
	logic [periph_pkg::DATA_W-1:0]   pwdata;
	logic [periph_pkg::STRB_W-1:0]   pstrb;
	wire                             pready;
	wire  [periph_pkg::DATA_W-1:0]   prdata;
	wire                             irq;
	wire                             check_busy;
	int                              pass_count;
	int                              fail_count;
	logic [31:0]                     vec_mem [FIELDS*MAX_TESTS];
	int                              issued;
	bit                              timed_out;

	periph_top dut_i (
		.clk24mhz  (clk24mhz),
		.rst_p     (rst_p),
		.psel_i    (psel),
		.penable_i (penable),
		.pwrite_i  (pwrite),
		.paddr_i   (paddr),
		.pwdata_i  (pwdata),
		.pstrb_i   (pstrb),
		.pready_o  (pready),
		.prdata_o  (prdata),
		.irq_o     (irq)
	);

	tb_checker checker_i (
		.clk24mhz     (clk24mhz),
		.rst_p        (rst_p),
		.psel_i       (psel),
		.penable_i    (penable),
		.pready_i     (pready),
		.prdata_i     (prdata),
		.irq_i        (irq),
		.busy_o       (check_busy),
		.pass_count_o (pass_count),
		.fail_count_o (fail_count)
	);

	always #20 clk24mhz = ~clk24mhz;

	task automatic idle_bus();
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = '0;
		pwdata  = '0;
		pstrb   = '0;
	endtask

	// Entered and left 2 ns after a rising edge
	task automatic run_access(input int idx);
		int wait_cycles;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = vec_mem[idx*FIELDS][0];
		paddr   = vec_mem[idx*FIELDS+1][periph_pkg::ADDR_W-1:0];
		pwdata  = vec_mem[idx*FIELDS+2];
		pstrb   = vec_mem[idx*FIELDS+3][periph_pkg::STRB_W-1:0];
		@(posedge clk24mhz);
		#2;
		penable = 1'b1;
		wait_cycles = 0;
		@(negedge clk24mhz);
		while (!pready && wait_cycles < READY_TIMEOUT) begin
			@(negedge clk24mhz);
			wait_cycles++;
		end
		if (!pready) begin
			$display("Timeout: access %0d to address %04h never got pready", idx, paddr);
			timed_out = 1'b1;
		end
		@(posedge clk24mhz);
		#2;
		idle_bus();
	endtask

	initial begin
		int gap;
		int wait_cycles;
		clk24mhz  = 1'b0;
		rst_p     = 1'b1;
		timed_out = 1'b0;
		issued    = 0;
		idle_bus();
		$readmemh("dv/golden_vectors.txt", vec_mem);
		void'($urandom(SEED));
		repeat (4) @(posedge clk24mhz);
		#2;
		rst_p = 1'b0;
		// An op other than read or write ends the list
		while (!timed_out && issued < MAX_TESTS &&
				(vec_mem[issued*FIELDS] == 32'h0 || vec_mem[issued*FIELDS] == 32'h1)) begin
			run_access(issued);
			issued++;
			gap = $urandom % 4;
			repeat (gap) begin
				@(posedge clk24mhz);
				#2;
			end
		end
		wait_cycles = 0;
		while (check_busy && wait_cycles < DRAIN_TIMEOUT) begin
			@(posedge clk24mhz);
			wait_cycles++;
		end
		if (check_busy) begin
			$display("Timeout: irq checks still outstanding at the end of the run");
			timed_out = 1'b1;
		end
		$display("Tests run %0d, passed %0d, failed %0d", issued, pass_count, fail_count);
		if (!timed_out && issued > 0 && fail_count == 0 && pass_count == issued) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* dv/tb_checker.sv */
//###########################################################################
// Peripheral subsystem response checker
// Watches the APB response and irq of the DUT and compares them with the
// golden vectors, one test per completed access
//###########################################################################
`timescale 1ns/100ps
`default_nettype none

module tb_checker (
	input  wire                           clk24mhz,
	input  wire                           rst_p,
	input  wire                           psel_i,
	input  wire                           penable_i,
	input  wire                           pready_i,
	input  wire  [periph_pkg::DATA_W-1:0] prdata_i,
	input  wire                           irq_i,
	output logic                          busy_o,
	output int                            pass_count_o,
	output int                            fail_count_o
);

	localparam int FIELDS    = 6;
	localparam int MAX_TESTS = 64;

	logic [31:0] vec_mem [FIELDS*MAX_TESTS];
	bit          test_bad [MAX_TESTS];
	int          cycle      = 0;
	int          done_count = 0;
	int          due_q [$];
	int          idx_q [$];

	initial begin
		pass_count_o = 0;
		fail_count_o = 0;
		busy_o       = 1'b0;
		$readmemh("dv/golden_vectors.txt", vec_mem);
	end

	function automatic string test_name(input int idx);
		string kind;
		kind = (vec_mem[idx*FIELDS] == 32'h1) ? "write" : "read";
		return $sformatf("test %0d %s %04h", idx, kind, vec_mem[idx*FIELDS+1][15:0]);
	endfunction

	// Closes a test once its irq sample is due
	task automatic check_irq(input int idx);
		logic exp_irq;
		exp_irq = vec_mem[idx*FIELDS+5][0];
		if (irq_i !== exp_irq) begin
			$display("FAIL %s irq expected %0b actual %0b", test_name(idx), exp_irq, irq_i);
			test_bad[idx] = 1'b1;
		end
		if (test_bad[idx]) begin
			fail_count_o++;
		end else begin
			$display("PASS %s", test_name(idx));
			pass_count_o++;
		end
	endtask

	// Sample at the falling edge, away from the register updates
	always @(negedge clk24mhz) begin : sample_bus
		int          idx;
		logic [31:0] exp_rd;
		if (!rst_p) begin
			cycle++;
			// Every access must finish in its first access cycle
			if (psel_i && penable_i && !pready_i && !test_bad[done_count]) begin
				$display("FAIL %s pready expected 1 actual 0", test_name(done_count));
				test_bad[done_count] = 1'b1;
			end
			if (psel_i && penable_i && pready_i) begin
				idx = done_count;
				done_count++;
				if (vec_mem[idx*FIELDS] == 32'h0) begin
					exp_rd = vec_mem[idx*FIELDS+4];
					if (prdata_i !== exp_rd) begin
						$display("FAIL %s prdata expected %08h actual %08h",
							test_name(idx), exp_rd, prdata_i);
						test_bad[idx] = 1'b1;
					end
				end
				// irq settles two cycles after the access ends
				due_q.push_back(cycle + 2);
				idx_q.push_back(idx);
			end
			if (due_q.size() > 0 && due_q[0] == cycle) begin
				idx = idx_q.pop_front();
				void'(due_q.pop_front());
				check_irq(idx);
			end
		end
		busy_o = (due_q.size() > 0);
	end

endmodule

`default_nettype wire

/* logic/periph_top.sv */
//###########################################################################
// Peripheral subsystem top
// APB decoder with device table, interrupt controller and four mailboxes
//###########################################################################
`timescale 1ns/100ps
`default_nettype none

module periph_top (
	input  wire                               clk24mhz,
	input  wire                               rst_p,
	input  wire                               psel_i,
	input  wire                               penable_i,
	input  wire                               pwrite_i,
	input  wire  [periph_pkg::ADDR_W-1:0]     paddr_i,
	input  wire  [periph_pkg::DATA_W-1:0]     pwdata_i,
	input  wire  [periph_pkg::STRB_W-1:0]     pstrb_i,
	output wire                               pready_o,
	output wire  [periph_pkg::DATA_W-1:0]     prdata_o,
	output wire                               irq_o
);

	wire [periph_pkg::SLOT_COUNT-1:0] slot_psel;
	wire [periph_pkg::SLOT_COUNT-1:0] slot_pready;
	wire [periph_pkg::DATA_W-1:0]     slot_prdata [periph_pkg::SLOT_COUNT];
	wire [periph_pkg::MBOX_COUNT-1:0] mbox_req;
	wire [periph_pkg::MBOX_COUNT-1:0] mbox_done;

	apb_slot_decoder decoder_i (
		.psel_i        (psel_i),
		.penable_i     (penable_i),
		.paddr_i       (paddr_i),
		.slot_pready_i (slot_pready),
		.slot_prdata_i (slot_prdata),
		.slot_psel_o   (slot_psel),
		.pready_o      (pready_o),
		.prdata_o      (prdata_o)
	);

	device_table devtbl_i (
		.psel_i    (slot_psel[periph_pkg::SLOT_DEVTBL]),
		.penable_i (penable_i),
		.paddr_i   (paddr_i),
		.pready_o  (slot_pready[periph_pkg::SLOT_DEVTBL]),
		.prdata_o  (slot_prdata[periph_pkg::SLOT_DEVTBL])
	);

	intr_ctrl intctrl_i (
		.clk24mhz    (clk24mhz),
		.rst_p       (rst_p),
		.psel_i      (slot_psel[periph_pkg::SLOT_INTCTRL]),
		.penable_i   (penable_i),
		.pwrite_i    (pwrite_i),
		.paddr_i     (paddr_i),
		.pwdata_i    (pwdata_i),
		.intr_req_i  (mbox_req),
		.pready_o    (slot_pready[periph_pkg::SLOT_INTCTRL]),
		.prdata_o    (slot_prdata[periph_pkg::SLOT_INTCTRL]),
		.intr_done_o (mbox_done),
		.irq_o       (irq_o)
	);

	// Mailbox i sits in slot SLOT_MBOX_FIRST+i and is interrupt source i
	for (genvar i = 0; i < periph_pkg::MBOX_COUNT; i++) begin : g_mbox
		mailbox_slot #(
			.MBOX_IDX (i)
		) mbox_i (
			.clk24mhz    (clk24mhz),
			.rst_p       (rst_p),
			.psel_i      (slot_psel[periph_pkg::SLOT_MBOX_FIRST + i]),
			.penable_i   (penable_i),
			.pwrite_i    (pwrite_i),
			.paddr_i     (paddr_i),
			.pwdata_i    (pwdata_i),
			.pstrb_i     (pstrb_i),
			.intr_done_i (mbox_done[i]),
			.pready_o    (slot_pready[periph_pkg::SLOT_MBOX_FIRST + i]),
			.prdata_o    (slot_prdata[periph_pkg::SLOT_MBOX_FIRST + i]),
			.intr_req_o  (mbox_req[i])
		);
	end

	// Catch-all slots have no device, the decoder answers for them
	for (genvar k = periph_pkg::SLOT_INVALID_FIRST; k < periph_pkg::SLOT_COUNT; k++) begin : g_none
		assign slot_pready[k] = 1'b0;
		assign slot_prdata[k] = '0;
	end

endmodule

`default_nettype wire

/* logic/intr_ctrl.sv */
//###########################################################################
// Interrupt controller
// Registers mailbox requests, reports the lowest pending source and
// returns a one-cycle done pulse when software acknowledges it
//###########################################################################
`timescale 1ns/100ps
`default_nettype none

module intr_ctrl (
	input  wire                                 clk24mhz,
	input  wire                                 rst_p,
	input  wire                                 psel_i,
	input  wire                                 penable_i,
	input  wire                                 pwrite_i,
	input  wire  [periph_pkg::ADDR_W-1:0]       paddr_i,
	input  wire  [periph_pkg::DATA_W-1:0]       pwdata_i,
	input  wire  [periph_pkg::MBOX_COUNT-1:0]   intr_req_i,
	output logic                                pready_o,
	output logic [periph_pkg::DATA_W-1:0]       prdata_o,
	output logic [periph_pkg::MBOX_COUNT-1:0]   intr_done_o,
	output logic                                irq_o
);

	logic [periph_pkg::REG_SEL_W-1:0]  reg_sel;
	logic [periph_pkg::MBOX_COUNT-1:0] pending_q;
	logic [periph_pkg::MBOX_COUNT-1:0] acked_q;
	logic [periph_pkg::MBOX_COUNT-1:0] visible;
	logic [periph_pkg::MBOX_COUNT-1:0] ack_onehot;
	logic [periph_pkg::INTR_ID_W-1:0]  ack_id;
	logic [periph_pkg::INTR_ID_W-1:0]  first_id;
	logic                              ack_fire;

	assign reg_sel  = paddr_i[periph_pkg::REG_SEL_LSB +: periph_pkg::REG_SEL_W];
	assign ack_id   = pwdata_i[periph_pkg::INTR_ID_W-1:0];
	assign pready_o = psel_i && penable_i;
	assign irq_o    = |pending_q;

	// Acknowledged sources stay hidden until the mailbox drops its request,
	// so a read right after the ack already shows the next source
	assign visible = pending_q & ~acked_q;

	assign ack_fire = psel_i && penable_i && pwrite_i &&
		(reg_sel == periph_pkg::REG_IC_ACK) && visible[ack_id];

	always_comb begin
		ack_onehot         = '0;
		ack_onehot[ack_id] = ack_fire;
	end

	// Lowest-numbered visible source wins
	always_comb begin
		first_id = '0;
		for (int s = periph_pkg::MBOX_COUNT - 1; s >= 0; s--) begin
			if (visible[s]) begin
				first_id = periph_pkg::INTR_ID_W'(s);
			end
		end
	end

	always_ff @(posedge clk24mhz) begin
		if (rst_p) begin
			pending_q   <= '0;
			acked_q     <= '0;
			intr_done_o <= '0;
		end else begin
			pending_q   <= intr_req_i;
			acked_q     <= (acked_q & intr_req_i) | ack_onehot;
			intr_done_o <= ack_onehot;
		end
	end

	always_comb begin
		prdata_o = '0;
		if (reg_sel == periph_pkg::REG_IC_PENDING) begin
			prdata_o[periph_pkg::DATA_W-1]        = |visible;
			prdata_o[periph_pkg::INTR_ID_W-1:0]   = first_id;
		end
	end

	// Done only reaches a source whose request is still registered
	assert property (@(posedge clk24mhz) disable iff (rst_p)
		(intr_done_o & ~pending_q) == '0)
		else $error("done for a source that is not pending: done %b pending %b",
			intr_done_o, pending_q);

endmodule

`default_nettype wire

/* logic/device_table.sv */
//###########################################################################
// Device table
// Read-only list of the device ID and interrupt use of every slot
//###########################################################################
`timescale 1ns/100ps
`default_nettype none

module device_table (
	input  wire                               psel_i,
	input  wire                               penable_i,
	input  wire  [periph_pkg::ADDR_W-1:0]     paddr_i,
	output logic                              pready_o,
	output logic [periph_pkg::DATA_W-1:0]     prdata_o
);

	logic [periph_pkg::SLOT_SEL_W-1:0] word_idx;
	logic [periph_pkg::DEV_ID_W-1:0]   dev_id;
	logic                              use_intr;

	// Word k describes slot k, writes are accepted and dropped
	assign word_idx = paddr_i[periph_pkg::REG_SEL_LSB +: periph_pkg::SLOT_SEL_W];
	assign pready_o = psel_i && penable_i;

	always_comb begin
		dev_id   = periph_pkg::DEV_ID_NONE;
		use_intr = 1'b0;
		if (word_idx == periph_pkg::SLOT_DEVTBL) begin
			dev_id = periph_pkg::DEV_ID_DEVTBL;
		end else if (word_idx == periph_pkg::SLOT_INTCTRL) begin
			dev_id = periph_pkg::DEV_ID_INTCTRL;
		end else if (word_idx >= periph_pkg::SLOT_MBOX_FIRST &&
				word_idx < periph_pkg::SLOT_INVALID_FIRST) begin
			// Only mailboxes raise interrupts
			dev_id   = periph_pkg::DEV_ID_MBOX;
			use_intr = 1'b1;
		end
	end

	// ID in the low byte, interrupt use in the top bit
	always_comb begin
		prdata_o = '0;
		prdata_o[periph_pkg::DEV_ID_W-1:0] = dev_id;
		prdata_o[periph_pkg::DATA_W-1]     = use_intr;
	end

endmodule

`default_nettype wire

/* logic/mailbox_slot.sv */
//###########################################################################
// Mailbox slot
// Byte-writable data word plus a doorbell that raises an interrupt
// request, held until the interrupt controller returns done
//###########################################################################
`timescale 1ns/100ps
`default_nettype none

module mailbox_slot #(
	parameter int unsigned MBOX_IDX = 0
) (
	input  wire                               clk24mhz,
	input  wire                               rst_p,
	input  wire                               psel_i,
	input  wire                               penable_i,
	input  wire                               pwrite_i,
	input  wire  [periph_pkg::ADDR_W-1:0]     paddr_i,
	input  wire  [periph_pkg::DATA_W-1:0]     pwdata_i,
	input  wire  [periph_pkg::STRB_W-1:0]     pstrb_i,
	input  wire                               intr_done_i,
	output logic                              pready_o,
	output logic [periph_pkg::DATA_W-1:0]     prdata_o,
	output logic                              intr_req_o
);

	logic [periph_pkg::REG_SEL_W-1:0] reg_sel;
	logic                             wr_en;
	logic [periph_pkg::DATA_W-1:0]    data_q;

	assign reg_sel  = paddr_i[periph_pkg::REG_SEL_LSB +: periph_pkg::REG_SEL_W];
	assign wr_en    = psel_i && penable_i && pwrite_i;
	assign pready_o = psel_i && penable_i;

	always_ff @(posedge clk24mhz) begin
		if (rst_p) begin
			data_q     <= '0;
			intr_req_o <= 1'b0;
		end else begin
			if (wr_en && reg_sel == periph_pkg::REG_MBOX_DATA) begin
				for (int b = 0; b < periph_pkg::STRB_W; b++) begin
					if (pstrb_i[b]) begin
						data_q[8*b +: 8] <= pwdata_i[8*b +: 8];
					end
				end
			end
			// A fresh doorbell wins over a done arriving in the same cycle
			if (intr_done_i) begin
				intr_req_o <= 1'b0;
			end
			if (wr_en && reg_sel == periph_pkg::REG_MBOX_DOORBELL && pwdata_i[0]) begin
				intr_req_o <= 1'b1;
			end
		end
	end

	always_comb begin
		prdata_o = '0;
		case (reg_sel)
			periph_pkg::REG_MBOX_DATA:     prdata_o = data_q;
			periph_pkg::REG_MBOX_DOORBELL: prdata_o[0] = intr_req_o;
			default:                       prdata_o = '0;
		endcase
	end

	// Controller may only complete a request this mailbox actually raised
	assert property (@(posedge clk24mhz) disable iff (rst_p)
		intr_done_i |-> intr_req_o)
		else $error("mailbox %0d got done without a pending request", MBOX_IDX);

endmodule

`default_nettype wire

/* logic/apb_slot_decoder.sv */
//###########################################################################
// APB slot decoder
// Routes the single requester's select to one 4 KB slot and returns that
// slot's ready and read data. Unmapped slots complete here and read zero
//###########################################################################
`timescale 1ns/100ps
`default_nettype none

module apb_slot_decoder (
	input  wire                                 psel_i,
	input  wire                                 penable_i,
	input  wire  [periph_pkg::ADDR_W-1:0]       paddr_i,
	input  wire  [periph_pkg::SLOT_COUNT-1:0]   slot_pready_i,
	input  wire  [periph_pkg::DATA_W-1:0]       slot_prdata_i [periph_pkg::SLOT_COUNT],
	output logic [periph_pkg::SLOT_COUNT-1:0]   slot_psel_o,
	output logic                                pready_o,
	output logic [periph_pkg::DATA_W-1:0]       prdata_o
);

	logic [periph_pkg::SLOT_SEL_W-1:0] slot_num;
	logic                              slot_valid;

	// Slot number sits right above the 4 KB window offset
	assign slot_num   = paddr_i[periph_pkg::SLOT_SEL_LSB +: periph_pkg::SLOT_SEL_W];
	assign slot_valid = (slot_num < periph_pkg::SLOT_INVALID_FIRST);

	// One select per mapped slot, none for the catch-all range
	always_comb begin
		slot_psel_o = '0;
		if (psel_i && slot_valid) begin
			slot_psel_o[slot_num] = 1'b1;
		end
	end

	// Invalid slots finish in the first access cycle on their own
	always_comb begin
		pready_o = 1'b0;
		if (psel_i && penable_i) begin
			if (slot_valid) begin
				pready_o = slot_pready_i[slot_num];
			end else begin
				pready_o = 1'b1;
			end
		end
	end

	always_comb begin
		if (slot_valid) begin
			prdata_o = slot_prdata_i[slot_num];
		end else begin
			prdata_o = '0;
		end
	end

endmodule

`default_nettype wire

/* logic/periph_pkg.sv */
//###########################################################################
// Peripheral subsystem package
// Address map, slot numbers, device IDs and register offsets shared by
// the APB decoder and every peripheral slot
//###########################################################################
`default_nettype none

package periph_pkg;

	// Bus widths
	localparam int unsigned ADDR_W = 16;
	localparam int unsigned DATA_W = 32;
	localparam int unsigned STRB_W = DATA_W / 8;

	// Every slot decodes a 4 KB window
	localparam int unsigned MAP_SIZE_SLOT = 4096;
	localparam int unsigned SLOT_SEL_LSB  = $clog2(MAP_SIZE_SLOT);
	localparam int unsigned SLOT_SEL_W    = 3;
	localparam int unsigned SLOT_COUNT    = 1 << SLOT_SEL_W;

	// Slot assignment, mailboxes fill slots 2 to 5
	localparam logic [SLOT_SEL_W-1:0] SLOT_DEVTBL        = 3'd0;
	localparam logic [SLOT_SEL_W-1:0] SLOT_INTCTRL       = 3'd1;
	localparam logic [SLOT_SEL_W-1:0] SLOT_MBOX_FIRST    = 3'd2;
	localparam int unsigned           MBOX_COUNT         = 4;
	localparam logic [SLOT_SEL_W-1:0] SLOT_INVALID_FIRST = 3'd6;

	// Device IDs as reported by the device table
	localparam int unsigned           DEV_ID_W       = 8;
	localparam logic [DEV_ID_W-1:0]   DEV_ID_DEVTBL  = 8'd7;
	localparam logic [DEV_ID_W-1:0]   DEV_ID_INTCTRL = 8'd3;
	localparam logic [DEV_ID_W-1:0]   DEV_ID_MBOX    = 8'd5;
	localparam logic [DEV_ID_W-1:0]   DEV_ID_NONE    = 8'd0;

	// Interrupt source index, one source per mailbox
	localparam int unsigned INTR_ID_W = $clog2(MBOX_COUNT);

	// Word offsets inside a window, taken from address bits 3..2
	localparam int unsigned          REG_SEL_LSB       = 2;
	localparam int unsigned          REG_SEL_W         = 2;
	localparam logic [REG_SEL_W-1:0] REG_MBOX_DATA     = 2'd0;
	localparam logic [REG_SEL_W-1:0] REG_MBOX_DOORBELL = 2'd1;
	localparam logic [REG_SEL_W-1:0] REG_IC_PENDING    = 2'd0;
	localparam logic [REG_SEL_W-1:0] REG_IC_ACK        = 2'd1;

endpackage

`default_nettype wire
